/* flist.f */
verilog/cnn_data_pkg.sv
verilog/cnn_ctrl_pkg.sv
verilog/cnn_ctrl.sv
verilog/fmap_feeder.sv
verilog/conv_window.sv
verilog/conv_mac.sv
verilog/pool_relu.sv
verilog/cnn_front_top.sv
testbench/tb_cnn_front.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log for the pass message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_cnn_front -f flist.f \
    -o sim_cnn_front > build.log 2>&1 \
    && ./obj_dir/sim_cnn_front > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "TESTBENCH PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* testbench/tb_cnn_front.sv */
`timescale 1ns/1ns

module tb_cnn_front;

    localparam int IX         = 8;
    localparam int IY         = 8;
    localparam int NPIX       = IX * IY;
    localparam int N_RES      = ((IX - 2) / 2) * ((IY - 2) / 2);
    localparam int CLK_PERIOD = 10;
    // loads of about eight frames plus a dozen runs.
    localparam int N_CMDS     = 8 * NPIX + 16;
    localparam longint WATCHDOG_CYCLES = longint'(N_CMDS) * (NPIX + 20) + 2000;

    logic                           clk = 1'b0;
    logic                           reset_n;
    logic                           req;
    cnn_ctrl_pkg::cnn_cmd_t         cmd;
    logic                           ack;
    logic [cnn_data_pkg::RES_W-1:0] result;
    logic                           result_valid;

    logic [7:0]  ref_mem [2][NPIX];
    logic [15:0] got_q[$];
    int          exp_q[$];
    integer      seed;
    int          error_count;

    cnn_front_top #(.IX(IX), .IY(IY)) i_cnn_front_top (
        .clk          (clk),
        .reset_n      (reset_n),
        .req          (req),
        .cmd          (cmd),
        .ack          (ack),
        .result       (result),
        .result_valid (result_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // kernel weight at row dy, column dx of the 3x3 window.
    function automatic int kernel_weight(cnn_ctrl_pkg::kernel_t k, int dy, int dx);
        int w;
        case (k)
            cnn_ctrl_pkg::KERN_IDENTITY: w = (dy == 1 && dx == 1) ? 1 : 0;
            cnn_ctrl_pkg::KERN_BLUR:     w = 1;
            cnn_ctrl_pkg::KERN_EDGE:     w = (dy == 1 && dx == 1) ? 8 : -1;
            default:                     w = (dx - 1) * ((dy == 1) ? 2 : 1);
        endcase
        return w;
    endfunction

    function automatic int conv_sum(cnn_ctrl_pkg::kernel_t k, int slot, int r, int c);
        int acc;
        acc = 0;
        for (int dy = 0; dy < 3; dy++) begin
            for (int dx = 0; dx < 3; dx++) begin
                acc += kernel_weight(k, dy, dx) * int'(ref_mem[slot][(r + dy) * IX + c + dx]);
            end
        end
        return acc;
    endfunction

    // best starts at zero, which also applies the ReLU.
    task automatic build_expected(input cnn_ctrl_pkg::kernel_t k, input int slot);
        int best;
        int sum;
        exp_q.delete();
        for (int pr = 0; pr < (IY - 2) / 2; pr++) begin
            for (int pc = 0; pc < (IX - 2) / 2; pc++) begin
                best = 0;
                for (int a = 0; a < 4; a++) begin
                    sum = conv_sum(k, slot, 2 * pr + a / 2, 2 * pc + a % 2);
                    if (sum > best) begin
                        best = sum;
                    end
                end
                exp_q.push_back(best);
            end
        end
    endtask

    // keeps req high for hold cycles, then drops it and expects ack to follow.
    task automatic release_req(input int hold);
        logic [31:0] rnd;
        rnd = $random(seed);
        cmd = cnn_ctrl_pkg::cnn_cmd_t'(rnd[21:0]);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value("ack", ack, 1);
        end
        req = 1'b0;
        @(negedge clk);
        check_value("ack", ack, 0);
    endtask

    task automatic load_pixel(input int slot, input int addr, input int hold);
        int waited;
        cmd       = '0;
        cmd.op    = cnn_ctrl_pkg::OP_LOAD;
        cmd.slot  = slot[0];
        cmd.addr  = 10'(addr);
        cmd.pixel = ref_mem[slot][addr];
        req       = 1'b1;
        waited    = 0;
        while (!ack) begin
            @(negedge clk);
            waited++;
            check_value("result_valid", result_valid, 0);
        end
        check_value("load ack latency", waited, 2);
        release_req(hold);
    endtask

    task automatic load_frame(input int slot);
        for (int a = 0; a < NPIX; a++) begin
            load_pixel(slot, a, 0);
        end
    endtask

    task automatic fill_random(input int slot);
        logic [31:0] rnd;
        for (int a = 0; a < NPIX; a++) begin
            rnd = $random(seed);
            ref_mem[slot][a] = rnd[7:0];
        end
    endtask

    task automatic run_frame(input cnn_ctrl_pkg::kernel_t k, input int slot, input int hold);
        cmd        = '0;
        cmd.op     = cnn_ctrl_pkg::OP_RUN;
        cmd.kernel = k;
        cmd.slot   = slot[0];
        req        = 1'b1;
        got_q.delete();
        while (!ack) begin
            @(negedge clk);
            if (result_valid) begin
                got_q.push_back(result);
            end
        end
        check_value("result count at ack", got_q.size(), N_RES);
        release_req(hold);
    endtask

    task automatic run_and_compare(input cnn_ctrl_pkg::kernel_t k, input int slot,
                                   input int hold);
        build_expected(k, slot);
        run_frame(k, slot, hold);
        for (int i = 0; i < N_RES; i++) begin
            check_value("result", got_q[i], exp_q[i]);
        end
    endtask

    task automatic idle_after_reset();
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_value("ack", ack, 0);
            check_value("result_valid", result_valid, 0);
        end
    endtask

    task automatic identity_pooling();
        fill_random(0);
        load_frame(0);
        run_and_compare(cnn_ctrl_pkg::KERN_IDENTITY, 0, 0);
    endtask

    task automatic kernel_sweep();
        fill_random(0);
        load_frame(0);
        run_and_compare(cnn_ctrl_pkg::KERN_BLUR, 0, 0);
        fill_random(0);
        load_frame(0);
        run_and_compare(cnn_ctrl_pkg::KERN_EDGE, 0, 0);
        fill_random(0);
        load_frame(0);
        run_and_compare(cnn_ctrl_pkg::KERN_SOBEL_X, 0, 0);
        // a falling ramp along each row makes every sobel_x sum negative.
        for (int a = 0; a < NPIX; a++) begin
            ref_mem[0][a] = 8'(250 - 30 * (a % IX) - a / IX);
        end
        load_frame(0);
        run_and_compare(cnn_ctrl_pkg::KERN_SOBEL_X, 0, 0);
        run_and_compare(cnn_ctrl_pkg::KERN_EDGE, 0, 0);
    endtask

    task automatic slot_selection();
        fill_random(0);
        for (int a = 0; a < NPIX; a++) begin
            ref_mem[1][a] = 8'(a * 37 + 11);
        end
        load_frame(0);
        load_frame(1);
        run_and_compare(cnn_ctrl_pkg::KERN_BLUR, 0, 0);
        run_and_compare(cnn_ctrl_pkg::KERN_BLUR, 1, 0);
        run_and_compare(cnn_ctrl_pkg::KERN_EDGE, 0, 0);
    endtask

    task automatic held_handshakes();
        ref_mem[1][IX + 2] = 8'hff;
        load_pixel(1, IX + 2, 3);
        run_and_compare(cnn_ctrl_pkg::KERN_SOBEL_X, 1, 4);
        run_and_compare(cnn_ctrl_pkg::KERN_IDENTITY, 0, 2);
    endtask

    initial begin
        seed        = 32'h754eb34d;
        error_count = 0;
        reset_n     = 1'b0;
        req         = 1'b0;
        cmd         = '0;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;

        idle_after_reset();
        identity_pooling();
        kernel_sweep();
        slot_selection();
        held_handshakes();

        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("simulation timed out waiting for the DUT to finish a command");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule

/* verilog/cnn_ctrl.sv */
`timescale 1ns/1ns

module cnn_ctrl #(
    parameter int IX = 8,
    parameter int IY = 8
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    req,
    input  cnn_ctrl_pkg::cnn_cmd_t  cmd,
    input  logic                    result_valid,
    output logic                    ack,
    output cnn_data_pkg::frame_wr_t frame_wr,
    output logic                    start,
    output logic                    run_slot,
    output cnn_ctrl_pkg::kernel_t   kernel
);

    // pooled results per frame.
    localparam int N_RES = ((IX - 2) / 2) * ((IY - 2) / 2);
    localparam int CNT_W = $clog2(N_RES + 1);

    cnn_ctrl_pkg::ctrl_state_t state;
    cnn_ctrl_pkg::cnn_cmd_t    cmd_q;
    logic [CNT_W-1:0]          res_cnt;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= cnn_ctrl_pkg::ST_IDLE;
            cmd_q   <= '0;
            res_cnt <= '0;
            start   <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                cnn_ctrl_pkg::ST_IDLE: begin
                    if (req) begin
                        // host may change cmd once ack is up.
                        cmd_q   <= cmd;
                        res_cnt <= '0;
                        if (cmd.op == cnn_ctrl_pkg::OP_RUN) begin
                            start <= 1'b1;
                            state <= cnn_ctrl_pkg::ST_RUN;
                        end else begin
                            state <= cnn_ctrl_pkg::ST_LOAD;
                        end
                    end
                end
                cnn_ctrl_pkg::ST_LOAD: begin
                    state <= cnn_ctrl_pkg::ST_ACK;
                end
                cnn_ctrl_pkg::ST_RUN: begin
                    if (result_valid) begin
                        res_cnt <= res_cnt + 1'b1;
                        if (res_cnt == CNT_W'(N_RES - 1)) begin
                            state <= cnn_ctrl_pkg::ST_ACK;
                        end
                    end
                end
                cnn_ctrl_pkg::ST_ACK: begin
                    if (!req) begin
                        state <= cnn_ctrl_pkg::ST_IDLE;
                    end
                end
                default: state <= cnn_ctrl_pkg::ST_IDLE;
            endcase
        end
    end

    assign ack = (state == cnn_ctrl_pkg::ST_ACK);

    // the frame write lasts the single ST_LOAD cycle.
    always_comb begin
        frame_wr.en    = (state == cnn_ctrl_pkg::ST_LOAD);
        frame_wr.slot  = cmd_q.slot;
        frame_wr.addr  = cmd_q.addr;
        frame_wr.pixel = cmd_q.pixel;
    end

    assign run_slot = cmd_q.slot;
    assign kernel   = cmd_q.kernel;

endmodule

/* verilog/cnn_ctrl_pkg.sv */
package cnn_ctrl_pkg;

    typedef enum logic [0:0] {
        OP_LOAD = 1'b0,
        OP_RUN  = 1'b1
    } cnn_op_t;

    typedef enum logic [1:0] {
        KERN_IDENTITY = 2'd0,
        KERN_BLUR     = 2'd1,
        KERN_EDGE     = 2'd2,
        KERN_SOBEL_X  = 2'd3
    } kernel_t;

    // load uses slot, addr and pixel; run uses kernel and slot.
    typedef struct packed {
        cnn_op_t                          op;
        kernel_t                          kernel;
        logic                             slot;
        logic [cnn_data_pkg::ADDR_W-1:0]  addr;
        logic [cnn_data_pkg::PIX_W-1:0]   pixel;
    } cnn_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_LOAD = 2'd1,
        ST_RUN  = 2'd2,
        ST_ACK  = 2'd3
    } ctrl_state_t;

endpackage

/* verilog/cnn_data_pkg.sv */
package cnn_data_pkg;

    localparam int PIX_W   = 8;
    localparam int COORD_W = 5;
    localparam int RES_W   = 16;
    localparam int ADDR_W  = 10;

    // one pixel of the raster stream.
    typedef struct packed {
        logic               valid;
        logic [PIX_W-1:0]   pixel;
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
    } pix_beat_t;

    // pix[0] is top-left, pix[8] bottom-right; row/col belong to pix[8].
    typedef struct packed {
        logic                  valid;
        logic [8:0][PIX_W-1:0] pix;
        logic [COORD_W-1:0]    row;
        logic [COORD_W-1:0]    col;
    } window_t;

    typedef struct packed {
        logic                    valid;
        logic signed [RES_W-1:0] sum;
        logic [COORD_W-1:0]      row;
        logic [COORD_W-1:0]      col;
    } conv_beat_t;

    typedef struct packed {
        logic              en;
        logic              slot;
        logic [ADDR_W-1:0] addr;
        logic [PIX_W-1:0]  pixel;
    } frame_wr_t;

endpackage

/* verilog/cnn_front_top.sv */
`timescale 1ns/1ns

module cnn_front_top #(
    parameter int IX = 8,
    parameter int IY = 8
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           req,
    input  cnn_ctrl_pkg::cnn_cmd_t         cmd,
    output logic                           ack,
    output logic [cnn_data_pkg::RES_W-1:0] result,
    output logic                           result_valid
);

    cnn_data_pkg::frame_wr_t  frame_wr;
    cnn_data_pkg::pix_beat_t  pix;
    cnn_data_pkg::window_t    win;
    cnn_data_pkg::conv_beat_t conv;
    cnn_ctrl_pkg::kernel_t    kernel;
    logic                     start;
    logic                     run_slot;

    cnn_ctrl #(.IX(IX), .IY(IY)) i_cnn_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .req          (req),
        .cmd          (cmd),
        .result_valid (result_valid),
        .ack          (ack),
        .frame_wr     (frame_wr),
        .start        (start),
        .run_slot     (run_slot),
        .kernel       (kernel)
    );

    fmap_feeder #(.IX(IX), .IY(IY)) i_fmap_feeder (
        .clk      (clk),
        .reset_n  (reset_n),
        .frame_wr (frame_wr),
        .start    (start),
        .run_slot (run_slot),
        .pix      (pix)
    );

    conv_window #(.IX(IX), .IY(IY)) i_conv_window (
        .clk     (clk),
        .reset_n (reset_n),
        .pix     (pix),
        .win     (win)
    );

    conv_mac i_conv_mac (
        .clk     (clk),
        .reset_n (reset_n),
        .win     (win),
        .kernel  (kernel),
        .conv    (conv)
    );

    pool_relu #(.IX(IX), .IY(IY)) i_pool_relu (
        .clk          (clk),
        .reset_n      (reset_n),
        .conv         (conv),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

/* verilog/conv_mac.sv */
`timescale 1ns/1ns

module conv_mac (
    input  logic                     clk,
    input  logic                     reset_n,
    input  cnn_data_pkg::window_t    win,
    input  cnn_ctrl_pkg::kernel_t    kernel,
    output cnn_data_pkg::conv_beat_t conv
);

    localparam int RES_W   = cnn_data_pkg::RES_W;
    localparam int COORD_W = cnn_data_pkg::COORD_W;

    logic signed [RES_W-1:0] acc;

    // coefficient at window position idx, row-major from top-left.
    function automatic logic signed [4:0] coef(cnn_ctrl_pkg::kernel_t k, int idx);
        logic signed [4:0] c;
        c = 5'sd0;
        case (k)
            cnn_ctrl_pkg::KERN_IDENTITY: c = (idx == 4) ? 5'sd1 : 5'sd0;
            cnn_ctrl_pkg::KERN_BLUR:     c = 5'sd1;
            cnn_ctrl_pkg::KERN_EDGE:     c = (idx == 4) ? 5'sd8 : -5'sd1;
            cnn_ctrl_pkg::KERN_SOBEL_X: begin
                if (idx % 3 == 0) begin
                    c = (idx == 3) ? -5'sd2 : -5'sd1;
                end else if (idx % 3 == 2) begin
                    c = (idx == 5) ? 5'sd2 : 5'sd1;
                end
            end
            default: c = 5'sd0;
        endcase
        return c;
    endfunction

    always_comb begin
        logic signed [RES_W-1:0] p;
        logic signed [RES_W-1:0] k;
        acc = '0;
        for (int i = 0; i < 9; i++) begin
            p   = RES_W'(win.pix[i]);
            k   = RES_W'(coef(kernel, i));
            acc = acc + p * k;
        end
    end

    // coordinates move to the window's top-left corner.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            conv <= '0;
        end else begin
            conv.valid <= win.valid;
            conv.sum   <= acc;
            conv.row   <= win.row - COORD_W'(2);
            conv.col   <= win.col - COORD_W'(2);
        end
    end

endmodule

/* verilog/conv_window.sv */
`timescale 1ns/1ns

module conv_window #(
    parameter int IX = 8,
    parameter int IY = 8
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  cnn_data_pkg::pix_beat_t pix,
    output cnn_data_pkg::window_t   win
);

    localparam int PIX_W = cnn_data_pkg::PIX_W;
    localparam int IDX_W = (IX > 1) ? $clog2(IX) : 1;

    // line1 holds the previous row, line2 the row before that.
    logic [PIX_W-1:0] line1 [IX];
    logic [PIX_W-1:0] line2 [IX];
    logic [IDX_W-1:0] col_idx;
    logic [PIX_W-1:0] top;
    logic [PIX_W-1:0] mid;
    logic             in_frame;

    assign col_idx = pix.col[IDX_W-1:0];
    assign top     = line2[col_idx];
    assign mid     = line1[col_idx];

    // edge windows hold pixels from the wrong row or column, so they never emit.
    assign in_frame = pix.valid && (pix.row >= 2) && (pix.col >= 2) &&
                      (int'(pix.row) < IY) && (int'(pix.col) < IX);

    always_ff @(posedge clk) begin
        if (pix.valid) begin
            line2[col_idx] <= mid;
            line1[col_idx] <= pix.pixel;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            win <= '0;
        end else begin
            win.valid <= in_frame;
            if (pix.valid) begin
                // shift each window row left by one column.
                for (int r = 0; r < 3; r++) begin
                    win.pix[r*3]   <= win.pix[r*3+1];
                    win.pix[r*3+1] <= win.pix[r*3+2];
                end
                win.pix[2] <= top;
                win.pix[5] <= mid;
                win.pix[8] <= pix.pixel;
                win.row    <= pix.row;
                win.col    <= pix.col;
            end
        end
    end

endmodule

/* verilog/fmap_feeder.sv */
`timescale 1ns/1ns

module fmap_feeder #(
    parameter int IX = 8,
    parameter int IY = 8
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  cnn_data_pkg::frame_wr_t frame_wr,
    input  logic                    start,
    input  logic                    run_slot,
    output cnn_data_pkg::pix_beat_t pix
);

    localparam int NPIX    = IX * IY;
    localparam int AW      = $clog2(NPIX);
    localparam int PIX_W   = cnn_data_pkg::PIX_W;
    localparam int COORD_W = cnn_data_pkg::COORD_W;

    logic [PIX_W-1:0]   mem [2][NPIX];
    logic               busy;
    logic               slot_q;
    logic               emit;
    logic               cur_slot;
    logic [AW-1:0]      addr;
    logic [AW-1:0]      cur_addr;
    logic [COORD_W-1:0] row;
    logic [COORD_W-1:0] col;
    logic [COORD_W-1:0] cur_row;
    logic [COORD_W-1:0] cur_col;
    logic               last_col;
    logic               last_row;

    always_ff @(posedge clk) begin
        if (frame_wr.en) begin
            mem[frame_wr.slot][frame_wr.addr[AW-1:0]] <= frame_wr.pixel;
        end
    end

    // start restarts the walk at pixel 0 in the same cycle.
    assign emit     = start | busy;
    assign cur_slot = start ? run_slot : slot_q;
    assign cur_addr = start ? '0 : addr;
    assign cur_row  = start ? '0 : row;
    assign cur_col  = start ? '0 : col;
    assign last_col = (cur_col == COORD_W'(IX - 1));
    assign last_row = (cur_row == COORD_W'(IY - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy   <= 1'b0;
            slot_q <= 1'b0;
            addr   <= '0;
            row    <= '0;
            col    <= '0;
            pix    <= '0;
        end else begin
            pix.valid <= emit;
            if (emit) begin
                pix.pixel <= mem[cur_slot][cur_addr];
                pix.row   <= cur_row;
                pix.col   <= cur_col;
                slot_q    <= cur_slot;
                addr      <= cur_addr + 1'b1;
                if (last_col) begin
                    col  <= '0;
                    row  <= cur_row + 1'b1;
                    busy <= !last_row;
                end else begin
                    col  <= cur_col + 1'b1;
                    row  <= cur_row;
                    busy <= 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/pool_relu.sv */
`timescale 1ns/1ns

module pool_relu #(
    parameter int IX = 8,
    parameter int IY = 8
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  cnn_data_pkg::conv_beat_t      conv,
    output logic [cnn_data_pkg::RES_W-1:0] result,
    output logic                          result_valid
);

    localparam int RES_W = cnn_data_pkg::RES_W;
    // pooled grid size; a trailing odd conv row or column is dropped.
    localparam int PX    = (IX - 2) / 2;
    localparam int PY    = (IY - 2) / 2;
    localparam int HB_W  = (PX > 1) ? $clog2(PX) : 1;

    logic [RES_W-1:0] half_buf [PX];
    logic [RES_W-1:0] relu;
    logic [RES_W-1:0] pair_lo;
    logic [RES_W-1:0] pair_max;
    logic [RES_W-1:0] blk_max;
    logic [HB_W-1:0]  pair_idx;
    logic             in_block;
    logic             emit;

    assign relu     = conv.sum[RES_W-1] ? '0 : $unsigned(conv.sum);
    assign pair_idx = conv.col[HB_W:1];
    assign pair_max = (relu > pair_lo) ? relu : pair_lo;
    assign blk_max  = (pair_max > half_buf[pair_idx]) ? pair_max : half_buf[pair_idx];
    assign in_block = (int'(conv.row >> 1) < PY) && (int'(conv.col >> 1) < PX);
    assign emit     = conv.valid && in_block && conv.row[0] && conv.col[0];

    // even col parks its value, odd col closes the pair.
    always_ff @(posedge clk) begin
        if (conv.valid && in_block) begin
            if (!conv.col[0]) begin
                pair_lo <= relu;
            end else if (!conv.row[0]) begin
                half_buf[pair_idx] <= pair_max;
            end else begin
                result <= blk_max;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= emit;
        end
    end

endmodule
